//--- hw/uart_byte_rx.sv
module uart_byte_rx
    import uart_link_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx,
    output rx_event_t rx_event
);

    rx_state_e state_d, state_q;

    logic rx_meta, rx_sync, rx_prev;
    logic [ctr_width-1:0] ctr_d, ctr_q;
    logic [2:0] bit_idx_d, bit_idx_q;
    logic [7:0] shift_d, shift_q;
    rx_event_t event_d;

    // Two flops bring the line into the clock domain, a third gives the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_comb begin
        state_d = state_q;
        ctr_d = ctr_q;
        bit_idx_d = bit_idx_q;
        shift_d = shift_q;
        event_d = '0;

        case (state_q)
            rx_idle: begin
                ctr_d = '0;
                bit_idx_d = '0;
                // Only a falling edge starts a frame, so a line stuck low
                // after a bad stop bit must go high first
                if (rx_prev && !rx_sync) begin
                    state_d = rx_start_bit;
                end
            end

            rx_start_bit: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == half_bit) begin
                    ctr_d = '0;
                    if (rx_sync) begin
                        // Too short for a start bit
                        state_d = rx_idle;
                    end else begin
                        state_d = rx_data_bits;
                    end
                end
            end

            rx_data_bits: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == bit_end) begin
                    ctr_d = '0;
                    shift_d = {rx_sync, shift_q[7:1]};
                    bit_idx_d = bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) begin
                        state_d = rx_stop_bit;
                    end
                end
            end

            rx_stop_bit: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == bit_end) begin
                    ctr_d = '0;
                    event_d.valid = 1'b1;
                    event_d.frame_error = !rx_sync;
                    event_d.data = shift_q;
                    state_d = rx_idle;
                end
            end

            default: begin
                state_d = rx_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= rx_idle;
            ctr_q <= '0;
            bit_idx_q <= '0;
            rx_event <= '0;
        end else begin
            state_q <= state_d;
            ctr_q <= ctr_d;
            bit_idx_q <= bit_idx_d;
            rx_event <= event_d;
        end
        shift_q <= shift_d;
    end

endmodule

//--- hw/uart_link_pkg.sv
package uart_link_pkg;

    // Serial timing, one bit on the line lasts this many clock cycles
    localparam int clk_per_bit = 16;

    localparam int word_bytes = 8;
    localparam int word_width = 64;

    localparam int ctr_width = $clog2(clk_per_bit);
    localparam int byte_index_width = $clog2(word_bytes);

    // Counter values at the end of a bit and at the middle of a bit
    localparam logic [ctr_width-1:0] bit_end = ctr_width'(clk_per_bit - 1);
    localparam logic [ctr_width-1:0] half_bit = ctr_width'(clk_per_bit / 2 - 1);

    localparam logic [byte_index_width-1:0] byte_last = byte_index_width'(word_bytes - 1);

    typedef enum logic [1:0] {
        tx_idle,
        tx_start_bit,
        tx_data_bits,
        tx_stop_bit
    } tx_state_e;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start_bit,
        rx_data_bits,
        rx_stop_bit
    } rx_state_e;

    // One received frame, frame_error only counts together with valid
    typedef struct packed {
        logic       valid;
        logic       frame_error;
        logic [7:0] data;
    } rx_event_t;

endpackage

//--- hw/uart_link_top.sv
module uart_link_top
    import uart_link_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Transmit side
    input  logic                  block,
    input  logic                  word_strobe,
    input  logic [word_width-1:0] word_in,
    output logic                  tx,
    output logic                  tx_busy,

    // Receive side
    input  logic                  rx,
    output logic [word_width-1:0] word_out,
    output logic                  word_valid,
    output logic                  frame_error
);

    rx_event_t rx_event;

    word_uart_tx u_tx (
        .clk         (clk),
        .rst         (rst),
        .block       (block),
        .word_strobe (word_strobe),
        .word_in     (word_in),
        .tx          (tx),
        .busy        (tx_busy)
    );

    // The serial line is looped outside, tx and rx are independent here
    uart_byte_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_event (rx_event)
    );

    word_assembler u_asm (
        .clk         (clk),
        .rst         (rst),
        .rx_event    (rx_event),
        .word_out    (word_out),
        .word_valid  (word_valid),
        .frame_error (frame_error)
    );

endmodule

//--- hw/word_assembler.sv
module word_assembler
    import uart_link_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  rx_event_t             rx_event,
    output logic [word_width-1:0] word_out,
    output logic                  word_valid,
    output logic                  frame_error
);

    logic [byte_index_width-1:0] byte_index;
    logic [word_width-1:0] word_q;
    logic [word_width-1:0] word_next;

    // New bytes enter at the top, so the first byte ends up in the low byte
    assign word_next = {rx_event.data, word_q[word_width-1:8]};

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_index <= '0;
            word_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            frame_error <= 1'b0;
            if (rx_event.valid) begin
                if (rx_event.frame_error) begin
                    // Partial word is dropped, the next byte starts a new word
                    byte_index <= '0;
                    frame_error <= 1'b1;
                end else if (byte_index == byte_last) begin
                    byte_index <= '0;
                    word_valid <= 1'b1;
                end else begin
                    byte_index <= byte_index + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_event.valid && !rx_event.frame_error) begin
            word_q <= word_next;
            if (byte_index == byte_last) begin
                word_out <= word_next;
            end
        end
    end

endmodule

//--- hw/word_uart_tx.sv
module word_uart_tx
    import uart_link_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  block,
    input  logic                  word_strobe,
    input  logic [word_width-1:0] word_in,
    output logic                  tx,
    output logic                  busy
);

    tx_state_e state_d, state_q;

    logic [ctr_width-1:0] ctr_d, ctr_q;
    logic [2:0] bit_idx_d, bit_idx_q;
    logic [byte_index_width-1:0] byte_cnt_d, byte_cnt_q;
    logic [word_width-1:0] data_d, data_q;
    logic tx_d, tx_q;
    logic busy_d, busy_q;

    assign tx = tx_q;
    assign busy = busy_q;

    always_comb begin
        state_d = state_q;
        ctr_d = ctr_q;
        bit_idx_d = bit_idx_q;
        byte_cnt_d = byte_cnt_q;
        data_d = data_q;
        tx_d = 1'b1;
        busy_d = 1'b1;

        case (state_q)
            tx_idle: begin
                ctr_d = '0;
                bit_idx_d = '0;
                byte_cnt_d = '0;
                // A held-off transmitter looks busy to the sender
                busy_d = block;
                if (word_strobe && !block) begin
                    data_d = word_in;
                    state_d = tx_start_bit;
                    busy_d = 1'b1;
                end
            end

            tx_start_bit: begin
                tx_d = 1'b0;
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == bit_end) begin
                    ctr_d = '0;
                    state_d = tx_data_bits;
                end
            end

            tx_data_bits: begin
                // The word shifts right so the next bit to send is always bit 0
                tx_d = data_q[0];
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == bit_end) begin
                    ctr_d = '0;
                    data_d = data_q >> 1;
                    bit_idx_d = bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) begin
                        state_d = tx_stop_bit;
                    end
                end
            end

            tx_stop_bit: begin
                tx_d = 1'b1;
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == bit_end) begin
                    ctr_d = '0;
                    if (byte_cnt_q == byte_last) begin
                        state_d = tx_idle;
                    end else begin
                        // Next frame starts right away, no idle gap on the line
                        byte_cnt_d = byte_cnt_q + 1'b1;
                        state_d = tx_start_bit;
                    end
                end
            end

            default: begin
                state_d = tx_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= tx_idle;
            ctr_q <= '0;
            bit_idx_q <= '0;
            byte_cnt_q <= '0;
            tx_q <= 1'b1;
            busy_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ctr_q <= ctr_d;
            bit_idx_q <= bit_idx_d;
            byte_cnt_q <= byte_cnt_d;
            tx_q <= tx_d;
            busy_q <= busy_d;
        end
        data_q <= data_d;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the UART link testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal \
    --top-module uart_link_tb \
    -f uart_link.f \
    -o uart_link_sim &&
./obj_dir/uart_link_sim ||
{
    echo "Build or simulation ended with an error" >&2
    exit 1
}

//--- sim/uart_link_tb.sv
module uart_link_tb
    import uart_link_pkg::*;
();

    typedef logic [7:0] byte_list_t [word_bytes];

    // One word is eight frames of ten bits each
    localparam int word_cycles = word_bytes * 10 * clk_per_bit;
    localparam int random_words = 16;
    // Room for about 25 words plus reset, the block wait and the framing test
    localparam int cycle_limit = 25 * word_cycles + 8000;

    logic clk;
    logic rst;
    logic block;
    logic word_strobe;
    logic [word_width-1:0] word_in;
    logic tx;
    logic tx_busy;
    logic rx;
    logic [word_width-1:0] word_out;
    logic word_valid;
    logic frame_error;

    logic loopback;
    logic rx_drive;
    integer seed;
    int cycle_count;
    int frame_err_count;
    logic [word_width-1:0] expected_q [$];

    assign rx = loopback ? tx : rx_drive;

    uart_link_top uut (
        .clk         (clk),
        .rst         (rst),
        .block       (block),
        .word_strobe (word_strobe),
        .word_in     (word_in),
        .tx          (tx),
        .tx_busy     (tx_busy),
        .rx          (rx),
        .word_out    (word_out),
        .word_valid  (word_valid),
        .frame_error (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reference model that places the first byte received in the low byte of the word
    function automatic logic [word_width-1:0] build_word(input byte_list_t bytes_in);
        logic [word_width-1:0] w;
        w = '0;
        for (int i = 0; i < word_bytes; i++) begin
            w[i*8 +: 8] = bytes_in[i];
        end
        return w;
    endfunction

    // Bit n of the serial stream for a word, counted from the first start bit
    function automatic logic frame_bit(input logic [word_width-1:0] w, input int n);
        logic b;
        int pos;
        pos = n % 10;
        if (pos == 0) begin
            b = 1'b0;
        end else if (pos == 9) begin
            b = 1'b1;
        end else begin
            b = w[(n / 10) * 8 + pos - 1];
        end
        return b;
    endfunction

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Waits for the transmitter, offers one word and checks every bit near its middle
    task automatic send_word(input logic [word_width-1:0] w);
        while (tx_busy) begin
            next_cycle();
        end
        word_in = w;
        word_strobe = 1'b1;
        expected_q.push_back(w);
        next_cycle();
        word_strobe = 1'b0;
        // The first start bit reaches tx one cycle after the strobe edge
        repeat (clk_per_bit / 2) begin
            next_cycle();
        end
        for (int n = 0; n < word_bytes * 10; n++) begin
            check("tx_busy", 64'(tx_busy), 64'd1);
            check("tx", 64'(tx), 64'(frame_bit(w, n)));
            repeat (clk_per_bit) begin
                next_cycle();
            end
        end
        while (tx_busy) begin
            next_cycle();
        end
    endtask

    task automatic wait_for_words();
        while (expected_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic drive_bit(input logic value);
        rx_drive = value;
        repeat (clk_per_bit) begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic stop_value);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_value);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_on_failure();
        end
    end

    always @(negedge clk) begin
        if (!rst && word_valid) begin
            if (expected_q.size() == 0) begin
                $display("A word arrived while no word was expected, word_out %h", word_out);
                stop_on_failure();
            end else begin
                check("word_out", word_out, expected_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && frame_error) begin
            frame_err_count++;
        end
    end

    initial begin
        byte_list_t last_bytes;
        int err_before;

        rst = 1'b1;
        block = 1'b0;
        word_strobe = 1'b0;
        word_in = '0;
        loopback = 1'b0;
        rx_drive = 1'b1;
        seed = 32'h867c_1261;
        cycle_count = 0;
        frame_err_count = 0;

        repeat (16) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b0;
        loopback = 1'b1;

        // Idle line after reset
        repeat (200) begin
            check("tx", 64'(tx), 64'd1);
            check("tx_busy", 64'(tx_busy), 64'd0);
            check("word_valid", 64'(word_valid), 64'd0);
            check("frame_error", 64'(frame_error), 64'd0);
            next_cycle();
        end

        send_word(64'h0);
        send_word(64'hffff_ffff_ffff_ffff);
        send_word(64'h0123_4567_89ab_cdef);
        send_word(64'haaaa_aaaa_aaaa_aaaa);
        wait_for_words();

        for (int i = 0; i < random_words; i++) begin
            send_word({$random(seed), $random(seed)});
        end
        wait_for_words();

        // A held-off transmitter ignores the strobe and keeps the line idle
        block = 1'b1;
        next_cycle();
        word_in = {$random(seed), $random(seed)};
        word_strobe = 1'b1;
        next_cycle();
        word_strobe = 1'b0;
        repeat (2000) begin
            check("tx_busy", 64'(tx_busy), 64'd1);
            check("tx", 64'(tx), 64'd1);
            next_cycle();
        end
        block = 1'b0;
        send_word({$random(seed), $random(seed)});
        wait_for_words();
        check("frame_error pulses", 64'(frame_err_count), 64'd0);

        // Framing error in the middle of a word
        rx_drive = 1'b1;
        next_cycle();
        loopback = 1'b0;
        repeat (2) begin
            drive_bit(1'b1);
        end
        err_before = frame_err_count;
        for (int i = 0; i < 3; i++) begin
            drive_frame(8'($random(seed)), 1'b1);
        end
        drive_frame(8'($random(seed)), 1'b0);
        // The line must go high again before the receiver takes a new start bit
        repeat (2) begin
            drive_bit(1'b1);
        end
        for (int i = 0; i < word_bytes; i++) begin
            last_bytes[i] = 8'($random(seed));
        end
        expected_q.push_back(build_word(last_bytes));
        for (int i = 0; i < word_bytes; i++) begin
            drive_frame(last_bytes[i], 1'b1);
        end
        wait_for_words();
        repeat (4 * clk_per_bit) begin
            next_cycle();
        end
        check("frame_error pulses", 64'(frame_err_count - err_before), 64'd1);

        if (expected_q.size() != 0) begin
            $display("%0d expected words never arrived", expected_q.size());
            stop_on_failure();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- uart_link.f
hw/uart_link_pkg.sv
hw/word_uart_tx.sv
hw/uart_byte_rx.sv
hw/word_assembler.sv
hw/uart_link_top.sv
sim/uart_link_tb.sv
